/* filelist.f */
dprio_pkg.sv
extra_csr_chain.sv
dprio_addr_decode.sv
ctrl_reg_bank.sv
stat_reg_bank.sv
dprio_read_mux.sv
dprio_csr_top.sv
tb_dprio_csr_top.sv

/* Makefile */
TOP = tb_dprio_csr_top

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

/* tb_dprio_csr_top.sv */
// Testbench with clock, reset, LFSR stimulus, reference model and checking assertions
`timescale 1ns/1ps

module tb_dprio_csr_top;

  localparam int RESET_CYCLES = 10;
  localparam int BUS_CYCLES   = 213;                        // Bus cycles over all phases
  localparam int TEST_CYCLES  = RESET_CYCLES + 3 * (dprio_pkg::CSR_CHAIN_LEN + 1) +
                                BUS_CYCLES + 10;
  localparam int CYCLE_LIMIT  = 7 * TEST_CYCLES;            // Generous margin
  localparam int STAT_W       = dprio_pkg::NUM_STATUS_REGS * dprio_pkg::DATA_WIDTH;
  localparam int CTRL_W       = dprio_pkg::NUM_CTRL_REGS * dprio_pkg::DATA_WIDTH;

  logic                  dprio_clk;
  logic                  reset;
  logic                  csr_in;
  logic                  csr_en;
  logic                  csr_out;
  dprio_pkg::extra_csr_t extra_csr;
  logic                  write;
  logic                  read;
  dprio_pkg::byte_en_t   byte_en;
  dprio_pkg::addr_t      reg_addr;
  dprio_pkg::data_t      writedata;
  dprio_pkg::data_t      readdata;
  logic                  block_select;
  logic [STAT_W-1:0]     user_datain;
  logic [CTRL_W-1:0]     user_dataout;

  logic [31:0]           lfsr;                              // Random source state
  int                    cycle_count = 0;
  dprio_pkg::extra_csr_t exp_csr;                           // Word last sent down the chain
  dprio_pkg::data_t      exp_ctrl [dprio_pkg::NUM_CTRL_REGS];
  dprio_pkg::data_t      exp_stat [dprio_pkg::NUM_STATUS_REGS];
  logic                  exp_sel;                           // Expected block select
  dprio_pkg::data_t      exp_rdata;                         // Expected read data
  logic [CTRL_W-1:0]     exp_dataout;
  dprio_pkg::addr_t      offset;                            // Address minus model base
  logic                  ctrl_off;
  logic                  stat_off;
  logic                  wr_hit;
  dprio_pkg::reg_idx_t   wr_idx;

  dprio_csr_top dut0 (
    .dprio_clk    (dprio_clk),
    .reset        (reset),
    .csr_in       (csr_in),
    .csr_en       (csr_en),
    .csr_out      (csr_out),
    .extra_csr    (extra_csr),
    .write        (write),
    .read         (read),
    .byte_en      (byte_en),
    .reg_addr     (reg_addr),
    .writedata    (writedata),
    .readdata     (readdata),
    .block_select (block_select),
    .user_datain  (user_datain),
    .user_dataout (user_dataout)
  );

  initial
  begin
    dprio_clk = 1'b0;
    forever #10 dprio_clk = ~dprio_clk;                     // 20 ns period
  end

  //**********************************************************
  // Random numbers and failure reporting
  //**********************************************************
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);                               // One step per bit
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] expv,
                                 input logic [63:0] actv);
    $display("error at %0t ns: %s expected %0h actual %0h", $time, name, expv, actv);
    $display("RESULT: FAIL");
    $fatal(1, "value mismatch");
  endtask

  always @(posedge dprio_clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("timeout after %0d cycles before the tests finished", cycle_count);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  //**********************************************************
  // Reference model
  //**********************************************************
  assign offset      = reg_addr - exp_csr.base_addr;        // Wraps like a 10-bit bus
  assign ctrl_off    = offset < dprio_pkg::addr_t'(dprio_pkg::STAT_OFFSET);
  assign stat_off    = (offset >= dprio_pkg::addr_t'(dprio_pkg::STAT_OFFSET)) &&
                       (offset <= dprio_pkg::addr_t'(dprio_pkg::STAT_OFFSET +
                                                     dprio_pkg::NUM_STATUS_REGS - 1));
  assign wr_idx      = ctrl_off ? dprio_pkg::reg_idx_t'(offset)
                                : dprio_pkg::reg_idx_t'(reg_addr); // Broadcast uses absolute
  assign wr_hit      = csr_en && write && (ctrl_off || (exp_csr.broadcast_en &&
                       (reg_addr < dprio_pkg::addr_t'(dprio_pkg::NUM_CTRL_REGS))));
  assign exp_dataout = {exp_ctrl[3], exp_ctrl[2], exp_ctrl[1], exp_ctrl[0]};

  always @(posedge dprio_clk)
  begin
    if (reset)
    begin
      for (int r = 0; r < dprio_pkg::NUM_CTRL_REGS; r++)
      begin
        exp_ctrl[r] <= '0;
      end
      for (int s = 0; s < dprio_pkg::NUM_STATUS_REGS; s++)
      begin
        exp_stat[s] <= '0;
      end
      exp_sel   <= 1'b0;
      exp_rdata <= '0;
    end
    else
    begin
      for (int s = 0; s < dprio_pkg::NUM_STATUS_REGS; s++)
      begin
        exp_stat[s] <= (csr_en && !exp_csr.power_iso_en) ? user_datain[16*s +: 16] : '0;
      end
      exp_sel <= csr_en && read && (ctrl_off || stat_off);
      if (csr_en && read && ctrl_off)
        exp_rdata <= exp_ctrl[offset[1:0]];
      else if (csr_en && read && stat_off)
        exp_rdata <= exp_stat[offset[0]];                   // Offset 4 is status 0
      else
        exp_rdata <= '0;
      for (int b = 0; b < dprio_pkg::NUM_BYTES; b++)
      begin
        if (wr_hit && byte_en[b])
          exp_ctrl[wr_idx][8*b +: 8] <= writedata[8*b +: 8];
      end
    end
  end

  a_dataout: assert property (@(posedge dprio_clk) disable iff (reset)
    user_dataout == exp_dataout)
    else report_mismatch("user_dataout", $sampled(exp_dataout), $sampled(user_dataout));
  a_select: assert property (@(posedge dprio_clk) disable iff (reset)
    block_select == exp_sel)
    else report_mismatch("block_select", 64'($sampled(exp_sel)), 64'($sampled(block_select)));
  a_readdata: assert property (@(posedge dprio_clk) disable iff (reset)
    readdata == exp_rdata)
    else report_mismatch("readdata", 64'($sampled(exp_rdata)), 64'($sampled(readdata)));
  a_csr_word: assert property (@(posedge dprio_clk) disable iff (reset)
    csr_en |-> (extra_csr == exp_csr))
    else report_mismatch("extra_csr", 64'($sampled(exp_csr)), 64'($sampled(extra_csr)));
  a_csr_out: assert property (@(posedge dprio_clk) disable iff (reset)
    csr_en |-> (csr_out == exp_csr[0]))                     // Serial out is bit 0
    else report_mismatch("csr_out", 64'($sampled(exp_csr[0])), 64'($sampled(csr_out)));

  //**********************************************************
  // Stimulus on the falling edge
  //**********************************************************
  task automatic drive_bus(input logic wr, input logic rd, input dprio_pkg::addr_t addr,
                           input dprio_pkg::byte_en_t be, input dprio_pkg::data_t data);
    @(negedge dprio_clk);
    write     = wr;
    read      = rd;
    reg_addr  = addr;
    byte_en   = be;
    writedata = data;
  endtask

  task automatic load_csr(input dprio_pkg::extra_csr_t word);
    for (int i = 0; i < dprio_pkg::CSR_CHAIN_LEN; i++)
    begin
      @(negedge dprio_clk);
      csr_en = 1'b0;
      csr_in = word[i];                                     // Bit 0 goes first
    end
    @(negedge dprio_clk);
    csr_en  = 1'b1;
    csr_in  = 1'b0;
    exp_csr = word;
  endtask

  initial
  begin
    dprio_pkg::addr_t base;
    dprio_pkg::addr_t a;
    lfsr        = 32'hdbce;
    reset       = 1'b1;
    csr_in      = 1'b0;
    csr_en      = 1'b0;
    write       = 1'b0;
    read        = 1'b0;
    byte_en     = '0;
    reg_addr    = '0;
    writedata   = '0;
    user_datain = '0;
    exp_csr     = '0;
    repeat (RESET_CYCLES) @(negedge dprio_clk);
    reset = 1'b0;
    base  = dprio_pkg::addr_t'(rand_bits(8)) | 10'h100;     // Nonzero base, room above
    load_csr('{power_iso_en: 1'b0, broadcast_en: 1'b0, reserved: 4'(rand_bits(4)),
               base_addr: base});
    for (int n = 0; n < 40; n++)                            // Writes with readback
    begin
      a = base + dprio_pkg::addr_t'(rand_bits(2));
      drive_bus(1'b1, 1'b0, a, 2'(rand_bits(2)), 16'(rand_bits(16)));
      drive_bus(1'b0, 1'b1, a, '0, '0);
    end
    for (int n = 0; n < 10; n++)                            // Status readback
    begin
      drive_bus(1'b0, 1'b0, '0, '0, '0);
      user_datain = rand_bits(32);
      drive_bus(1'b0, 1'b1, base + 10'd4, '0, '0);
      drive_bus(1'b0, 1'b1, base + 10'd5, '0, '0);
    end
    for (int n = 0; n < 10; n++)                            // Misses on both sides
    begin
      a = base + 10'd6 + dprio_pkg::addr_t'(rand_bits(6));
      drive_bus(1'b1, 1'b0, a, 2'b11, 16'(rand_bits(16)));
      drive_bus(1'b0, 1'b1, a, '0, '0);
      drive_bus(1'b1, 1'b0, dprio_pkg::addr_t'(rand_bits(2)), 2'b11, 16'(rand_bits(16)));
      drive_bus(1'b0, 1'b1, base - 10'd1 - dprio_pkg::addr_t'(rand_bits(6)), '0, '0);
    end
    load_csr('{power_iso_en: 1'b0, broadcast_en: 1'b1, reserved: 4'(rand_bits(4)),
               base_addr: base});
    for (int n = 0; n < 10; n++)                            // Broadcast writes
    begin
      a = dprio_pkg::addr_t'(rand_bits(2));
      drive_bus(1'b1, 1'b0, a, 2'(rand_bits(2)), 16'(rand_bits(16)));
      drive_bus(1'b0, 1'b1, base + a, '0, '0);
    end
    load_csr('{power_iso_en: 1'b1, broadcast_en: 1'b0, reserved: 4'(rand_bits(4)),
               base_addr: base});
    for (int n = 0; n < 10; n++)                            // Isolated status
    begin
      drive_bus(1'b0, 1'b0, '0, '0, '0);
      user_datain = rand_bits(32);
      drive_bus(1'b0, 1'b1, base + 10'd4, '0, '0);
      drive_bus(1'b0, 1'b1, base + 10'd5, '0, '0);
      drive_bus(1'b0, 1'b1, base + dprio_pkg::addr_t'(rand_bits(2)), '0, '0);
    end
    repeat (3) drive_bus(1'b0, 1'b0, '0, '0, '0);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* dprio_csr_top.sv */
// DPRIO control and status block top level
`timescale 1ns/1ps

module dprio_csr_top (
  input  logic                  dprio_clk,                  // Block clock
  input  logic                  reset,                      // Sync reset, active high
  input  logic                  csr_in,                     // Serial chain in
  input  logic                  csr_en,                     // Low loads the chain
  output logic                  csr_out,                    // Serial chain out
  output dprio_pkg::extra_csr_t extra_csr,                  // Loaded CSR word
  input  logic                  write,                      // Write strobe
  input  logic                  read,                       // Read strobe
  input  dprio_pkg::byte_en_t   byte_en,                    // Byte lanes
  input  dprio_pkg::addr_t      reg_addr,                   // Absolute address
  input  dprio_pkg::data_t      writedata,                  // Write payload
  output dprio_pkg::data_t      readdata,                   // Registered read data
  output logic                  block_select,               // Registered hit flag
  input  logic [dprio_pkg::NUM_STATUS_REGS*dprio_pkg::DATA_WIDTH-1:0] user_datain,
  output logic [dprio_pkg::NUM_CTRL_REGS*dprio_pkg::DATA_WIDTH-1:0]   user_dataout
);

  dprio_pkg::dprio_req_t    req;                            // Bundled bus inputs
  dprio_pkg::dprio_access_t access;                         // Decoded access
  dprio_pkg::data_t         ctrl_regs [dprio_pkg::NUM_CTRL_REGS];
  dprio_pkg::data_t         stat_regs [dprio_pkg::NUM_STATUS_REGS];

  assign req = '{write: write, read: read, byte_en: byte_en,
                 reg_addr: reg_addr, writedata: writedata};

  //**********************************************************
  // Configuration chain and decode
  //**********************************************************
  extra_csr_chain u_chain (
    .dprio_clk (dprio_clk),
    .reset     (reset),
    .csr_in    (csr_in),
    .csr_en    (csr_en),
    .csr_out   (csr_out),
    .extra_csr (extra_csr)                                  // Shared by decode and status
  );

  dprio_addr_decode u_decode (
    .dprio_clk (dprio_clk),
    .req       (req),
    .extra_csr (extra_csr),
    .csr_en    (csr_en),
    .access    (access)
  );

  //**********************************************************
  // Register banks and read path
  //**********************************************************
  ctrl_reg_bank u_ctrl (
    .dprio_clk    (dprio_clk),
    .reset        (reset),
    .access       (access),
    .ctrl_regs    (ctrl_regs),
    .user_dataout (user_dataout)
  );

  stat_reg_bank u_stat (
    .dprio_clk   (dprio_clk),
    .reset       (reset),
    .csr_en      (csr_en),
    .extra_csr   (extra_csr),                               // Isolation source
    .user_datain (user_datain),
    .stat_regs   (stat_regs)
  );

  dprio_read_mux u_rdmux (
    .dprio_clk    (dprio_clk),
    .reset        (reset),
    .access       (access),
    .ctrl_regs    (ctrl_regs),
    .stat_regs    (stat_regs),
    .readdata     (readdata),
    .block_select (block_select)
  );

endmodule

/* dprio_read_mux.sv */
// Read data select and registered block select
`timescale 1ns/1ps

module dprio_read_mux (
  input  logic                     dprio_clk,               // Block clock
  input  logic                     reset,                   // Sync reset, active high
  input  dprio_pkg::dprio_access_t access,                  // Decoded access
  input  dprio_pkg::data_t         ctrl_regs [dprio_pkg::NUM_CTRL_REGS],
  input  dprio_pkg::data_t         stat_regs [dprio_pkg::NUM_STATUS_REGS],
  output dprio_pkg::data_t         readdata,                // One cycle after read
  output logic                     block_select             // This block answers
);

  dprio_pkg::data_t rd_word;                                // Selected word

  // Misses fall through as zero
  always_comb
  begin
    rd_word = '0;
    for (int c = 0; c < dprio_pkg::NUM_CTRL_REGS; c++)
    begin
      if (access.rd_ctrl && (access.idx == dprio_pkg::reg_idx_t'(c)))
        rd_word = ctrl_regs[c];
    end
    for (int s = 0; s < dprio_pkg::NUM_STATUS_REGS; s++)
    begin
      if (access.rd_stat && (access.idx == dprio_pkg::reg_idx_t'(s)))
        rd_word = stat_regs[s];
    end
  end

  //**********************************************************
  // Registered response
  //**********************************************************
  always_ff @(posedge dprio_clk)
  begin
    if (reset)
    begin
      readdata     <= '0;
      block_select <= 1'b0;
    end
    else
    begin
      readdata     <= rd_word;                              // Zero on a miss
      block_select <= access.rd_ctrl || access.rd_stat;     // Hit in either bank
    end
  end

  // Data lines stay quiet unless this block answers
  property p_zero_on_miss;
    @(posedge dprio_clk) disable iff (reset)
      !block_select |-> (readdata == '0);
  endproperty

  a_zero_on_miss: assert property (p_zero_on_miss)
    else $error("readdata nonzero while block_select was low");

endmodule

/* stat_reg_bank.sv */
// Status sampling registers with power isolation
`timescale 1ns/1ps

module stat_reg_bank (
  input  logic                  dprio_clk,                  // Block clock
  input  logic                  reset,                      // Sync reset, active high
  input  logic                  csr_en,                     // Register port live
  input  dprio_pkg::extra_csr_t extra_csr,                  // Isolation enable
  input  logic [dprio_pkg::NUM_STATUS_REGS*dprio_pkg::DATA_WIDTH-1:0] user_datain,
  output dprio_pkg::data_t      stat_regs [dprio_pkg::NUM_STATUS_REGS] // Sampled status
);

  logic iso;                                                // Clamp the inputs

  // User logic may be powered down while the chain loads or isolation is on
  assign iso = !csr_en || extra_csr.power_iso_en;

  //**********************************************************
  // Sample every cycle
  //**********************************************************
  always_ff @(posedge dprio_clk)
  begin
    for (int s = 0; s < dprio_pkg::NUM_STATUS_REGS; s++)
    begin
      if (reset || iso)
      begin
        stat_regs[s] <= '0;                                 // Isolated reads as zero
      end
      else
      begin
        stat_regs[s] <= user_datain[s*dprio_pkg::DATA_WIDTH +: dprio_pkg::DATA_WIDTH];
      end
    end
  end

endmodule

/* ctrl_reg_bank.sv */
// Control register bank with byte-enabled writes
`timescale 1ns/1ps

module ctrl_reg_bank (
  input  logic                    dprio_clk,                // Block clock
  input  logic                    reset,                    // Sync reset, active high
  input  dprio_pkg::dprio_access_t access,                  // Decoded access
  output dprio_pkg::data_t        ctrl_regs [dprio_pkg::NUM_CTRL_REGS], // Bank contents
  output logic [dprio_pkg::NUM_CTRL_REGS*dprio_pkg::DATA_WIDTH-1:0] user_dataout
);

  //**********************************************************
  // Byte-masked register update
  //**********************************************************
  always_ff @(posedge dprio_clk)
  begin
    if (reset)
    begin
      for (int r = 0; r < dprio_pkg::NUM_CTRL_REGS; r++)
      begin
        ctrl_regs[r] <= '0;                                 // Outputs idle low
      end
    end
    else if (access.wr_ctrl)
    begin
      for (int b = 0; b < dprio_pkg::NUM_BYTES; b++)
      begin
        if (access.byte_en[b])                              // One lane per enable
        begin
          ctrl_regs[access.idx][8*b +: 8] <= access.writedata[8*b +: 8];
        end
      end
    end
  end

  // Flatten the bank for the user logic, register 0 in the low word
  genvar g;
  generate
    for (g = 0; g < dprio_pkg::NUM_CTRL_REGS; g++)
    begin : g_flat
      assign user_dataout[g*dprio_pkg::DATA_WIDTH +: dprio_pkg::DATA_WIDTH] = ctrl_regs[g];
    end
  endgenerate

  // A write with every lane masked leaves the user outputs untouched
  property p_no_lane_no_change;
    @(posedge dprio_clk) disable iff (reset)
      (access.wr_ctrl && (access.byte_en == '0)) |=> $stable(user_dataout);
  endproperty

  a_no_lane_no_change: assert property (p_no_lane_no_change)
    else $error("control bank changed on a write with no byte enable");

endmodule

/* dprio_addr_decode.sv */
// Base-relative address decode with broadcast control writes
`timescale 1ns/1ps

module dprio_addr_decode (
  input  logic                     dprio_clk,               // Only clocks the check
  input  dprio_pkg::dprio_req_t    req,                     // Raw bus request
  input  dprio_pkg::extra_csr_t    extra_csr,               // Base and broadcast
  input  logic                     csr_en,                  // Register port live
  output dprio_pkg::dprio_access_t access                   // Decoded access
);

  dprio_pkg::addr_t offset;                                 // Address minus base
  logic             ctrl_hit;                               // Offset 0 to 3
  logic             stat_hit;                               // Offset 4 to 5
  logic             bcast_hit;                              // Absolute 0 to 3

  //**********************************************************
  // Range checks and bank select
  //**********************************************************
  always_comb
  begin
    offset   = req.reg_addr - extra_csr.base_addr;          // Wraps modulo 1024
    ctrl_hit = offset < dprio_pkg::addr_t'(dprio_pkg::STAT_OFFSET);
    stat_hit = !ctrl_hit &&
               (offset < dprio_pkg::addr_t'(dprio_pkg::STAT_OFFSET +
                                            dprio_pkg::NUM_STATUS_REGS));
    // Broadcast only catches writes that miss the local window
    bcast_hit = extra_csr.broadcast_en && !ctrl_hit && !stat_hit &&
                (req.reg_addr < dprio_pkg::addr_t'(dprio_pkg::NUM_CTRL_REGS));

    access           = '0;
    access.wr_ctrl   = csr_en && req.write && (ctrl_hit || bcast_hit);
    access.rd_ctrl   = csr_en && req.read && ctrl_hit;
    access.rd_stat   = csr_en && req.read && stat_hit;
    access.byte_en   = req.byte_en;                         // Lanes pass as is
    access.writedata = req.writedata;

    if (bcast_hit)
    begin
      access.idx = dprio_pkg::reg_idx_t'(req.reg_addr);     // Absolute address as index
    end
    else if (stat_hit)
    begin
      access.idx = dprio_pkg::reg_idx_t'(offset -
                   dprio_pkg::addr_t'(dprio_pkg::STAT_OFFSET));
    end
    else
    begin
      access.idx = dprio_pkg::reg_idx_t'(offset);           // Control bank index
    end
  end

  // Chosen bank and index must map back onto the requested address
  property p_idx_legal;
    @(posedge dprio_clk)
      (access.wr_ctrl || access.rd_stat) |->
        (access.rd_stat ?
           ((access.idx < dprio_pkg::reg_idx_t'(dprio_pkg::NUM_STATUS_REGS)) &&
            (req.reg_addr == extra_csr.base_addr +
                             dprio_pkg::addr_t'(dprio_pkg::STAT_OFFSET) +
                             dprio_pkg::addr_t'(access.idx))) :
           ((req.reg_addr == extra_csr.base_addr + dprio_pkg::addr_t'(access.idx)) ||
            (extra_csr.broadcast_en &&
             (req.reg_addr == dprio_pkg::addr_t'(access.idx)))));
  endproperty

  a_idx_legal: assert property (p_idx_legal)
    else $error("decoded bank index does not match the bus address");

endmodule

/* extra_csr_chain.sv */
// Serial configuration shift register holding the extra CSR word
`timescale 1ns/1ps

module extra_csr_chain (
  input  logic                  dprio_clk,                  // Block clock
  input  logic                  reset,                      // Sync reset, active high
  input  logic                  csr_in,                     // Serial data in
  input  logic                  csr_en,                     // Low shifts, high holds
  output logic                  csr_out,                    // Serial data out
  output dprio_pkg::extra_csr_t extra_csr                   // Parallel CSR word
);

  logic [dprio_pkg::CSR_CHAIN_LEN-1:0] shreg;               // Chain bits

  //**********************************************************
  // Shift while the chain is open
  //**********************************************************
  always_ff @(posedge dprio_clk)
  begin
    if (reset)
    begin
      shreg <= '0;                                          // Clear whole word
    end
    else if (!csr_en)
    begin
      // New bit enters at the top, oldest falls out at bit 0
      shreg <= {csr_in, shreg[dprio_pkg::CSR_CHAIN_LEN-1:1]};
    end
  end

  assign csr_out   = shreg[0];                              // Sixteen bits back
  assign extra_csr = dprio_pkg::extra_csr_t'(shreg);        // Field view of chain

  // Word must not move once the register port is live
  property p_hold_when_enabled;
    @(posedge dprio_clk) disable iff (reset)
      csr_en |=> $stable(extra_csr);
  endproperty

  a_hold_when_enabled: assert property (p_hold_when_enabled)
    else $error("extra_csr changed while csr_en was high");

endmodule

/* dprio_pkg.sv */
// DPRIO register core sizes, address map, extra CSR layout and bus structs
package dprio_pkg;

  //**********************************************************
  // Sizes and address map
  //**********************************************************
  localparam int unsigned DATA_WIDTH      = 16;             // Register width
  localparam int unsigned ADDR_WIDTH      = 10;             // Address width
  localparam int unsigned NUM_CTRL_REGS   = 4;              // Control registers
  localparam int unsigned NUM_STATUS_REGS = 2;              // Status registers
  localparam int unsigned NUM_BYTES       = DATA_WIDTH / 8; // Byte lanes per word
  localparam int unsigned CSR_CHAIN_LEN   = 16;             // Serial chain length
  localparam int unsigned STAT_OFFSET     = 4;              // First status offset

  typedef logic [DATA_WIDTH-1:0] data_t;                    // Register word
  typedef logic [ADDR_WIDTH-1:0] addr_t;                    // Bus address
  typedef logic [NUM_BYTES-1:0]  byte_en_t;                 // Byte enables
  typedef logic [1:0]            reg_idx_t;                 // Index within a bank

  //**********************************************************
  // Extra CSR word, loaded through the serial chain
  //**********************************************************
  typedef struct packed {
    logic       power_iso_en;                               // Bit 15 forces status to zero
    logic       broadcast_en;                               // Bit 14 enables broadcast writes
    logic [3:0] reserved;                                   // Spare bits
    addr_t      base_addr;                                  // Base of this block
  } extra_csr_t;

  // Raw bus request as seen at the block boundary
  typedef struct packed {
    logic     write;                                        // Write strobe
    logic     read;                                         // Read strobe
    byte_en_t byte_en;                                      // Byte lanes
    addr_t    reg_addr;                                     // Absolute address
    data_t    writedata;                                    // Write payload
  } dprio_req_t;

  // Decoded access handed to the banks
  typedef struct packed {
    logic     wr_ctrl;                                      // Control write hit
    logic     rd_ctrl;                                      // Control read hit
    logic     rd_stat;                                      // Status read hit
    reg_idx_t idx;                                          // Register within bank
    byte_en_t byte_en;                                      // Byte lanes
    data_t    writedata;                                    // Write payload
  } dprio_access_t;

endpackage
